// ==== include/rp_macros.svh ====
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// ADC sample and decimated sum widths
`define RP_SAMPLE_W     14
`define RP_DECIM        4
`define RP_SUM_W        16   // Sample width plus log2 of RP_DECIM

// Sample FIFO in the user domain
`define RP_FIFO_DEPTH   8
`define RP_PTR_W        3

// Behavioral clock generation
`define RP_USR_DIV      2    // ADC clock cycles per user clock cycle
`define RP_LOCK_CYCLES  16   // ADC clock cycles until lock is reported

`endif

// ==== logic/rp_pkg.sv ====
`include "rp_macros.svh"

package rp_pkg;

    typedef logic [`RP_SAMPLE_W-1:0] adc_sample_t;  // Raw unsigned ADC word
    typedef logic [`RP_SUM_W-1:0]    sum_word_t;    // Sum of RP_DECIM samples
    typedef logic [`RP_PTR_W-1:0]    fifo_ptr_t;

    // Word held stable across the req/ack crossing
    typedef struct packed {
        logic        seq;     // Alternates per crossed sample
        adc_sample_t sample;
    } cdc_sample_s;

    // Producer side of the four-phase crossing
    typedef enum logic [1:0] {
        IDLE,
        REQ_HIGH,
        WAIT_ACK_LOW
    } xfer_state_e;

    typedef enum logic {
        ACCUM,
        HOLD
    } decim_state_e;

endpackage

// ==== logic/rp_infrastructure.sv ====
`include "rp_macros.svh"

module rp_infrastructure (
    input  logic adc_clk_in,
    input  logic arst_n,
    output logic usr_clk,
    output logic adc_rst,
    output logic usr_rst,
    output logic adc_mmcm_locked
);

    localparam int LOCK_W = $clog2(`RP_LOCK_CYCLES);
    localparam int HALF   = `RP_USR_DIV / 2;
    localparam int DIV_W  = $clog2(`RP_USR_DIV) + 1;

    logic [LOCK_W-1:0] lock_cnt;
    logic [DIV_W-1:0]  div_cnt;
    logic [1:0]        adc_rst_sync;
    logic [1:0]        usr_rst_sync;

    // Stand-in for the MMCM lock time
    always_ff @(posedge adc_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            lock_cnt        <= '0;
            adc_mmcm_locked <= 1'b0;
        end else if (!adc_mmcm_locked) begin
            if (lock_cnt == LOCK_W'(`RP_LOCK_CYCLES - 1))
                adc_mmcm_locked <= 1'b1;
            else
                lock_cnt <= lock_cnt + 1'b1;
        end
    end

    // Toggle divider, usr_clk flips every HALF ADC cycles
    always_ff @(posedge adc_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            usr_clk <= 1'b0;
        end else if (div_cnt == DIV_W'(HALF - 1)) begin
            div_cnt <= '0;
            usr_clk <= ~usr_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Assert at once, release two ADC clocks after lock
    always_ff @(posedge adc_clk_in or negedge arst_n) begin
        if (!arst_n)
            adc_rst_sync <= 2'b11;
        else
            adc_rst_sync <= {adc_rst_sync[0], ~adc_mmcm_locked};
    end

    // Lock also crosses into the user domain through these two flops
    always_ff @(posedge usr_clk or negedge arst_n) begin
        if (!arst_n)
            usr_rst_sync <= 2'b11;
        else
            usr_rst_sync <= {usr_rst_sync[0], ~adc_mmcm_locked};
    end

    assign adc_rst = adc_rst_sync[1];
    assign usr_rst = usr_rst_sync[1];

endmodule

// ==== logic/adc_capture.sv ====
module adc_capture (
    input  logic                adc_clk_in,
    input  logic                adc_rst,
    input  logic                adc_valid,
    input  rp_pkg::adc_sample_t adc_data,
    output logic                adc_ready,
    output logic                xfer_req,
    output rp_pkg::cdc_sample_s xfer_data,
    input  logic                xfer_ack
);

    rp_pkg::xfer_state_e state;
    logic                seq;
    logic                ack_meta;
    logic                ack_sync;
    logic                accept;

    assign accept = adc_valid & adc_ready;

    // Ack comes from the user domain
    always_ff @(posedge adc_clk_in or posedge adc_rst) begin
        if (adc_rst) begin
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= xfer_ack;
            ack_sync <= ack_meta;
        end
    end

    always_ff @(posedge adc_clk_in or posedge adc_rst) begin
        if (adc_rst) begin
            state     <= rp_pkg::IDLE;
            adc_ready <= 1'b0;   // Raised one cycle after reset
            xfer_req  <= 1'b0;
            seq       <= 1'b0;
        end else begin
            case (state)
                rp_pkg::IDLE: begin
                    if (accept) begin
                        state     <= rp_pkg::REQ_HIGH;
                        adc_ready <= 1'b0;
                        xfer_req  <= 1'b1;
                        seq       <= ~seq;
                    end else begin
                        adc_ready <= 1'b1;
                    end
                end
                rp_pkg::REQ_HIGH: begin
                    if (ack_sync) begin
                        state    <= rp_pkg::WAIT_ACK_LOW;
                        xfer_req <= 1'b0;
                    end
                end
                rp_pkg::WAIT_ACK_LOW: begin
                    if (!ack_sync) begin
                        state     <= rp_pkg::IDLE;
                        adc_ready <= 1'b1;
                    end
                end
                default: state <= rp_pkg::IDLE;
            endcase
        end
    end

    // Loaded together with the req rise, frozen until the next accept
    always_ff @(posedge adc_clk_in) begin
        if (accept) begin
            xfer_data.seq    <= seq;
            xfer_data.sample <= adc_data;
        end
    end

endmodule

// ==== logic/sample_fifo.sv ====
`include "rp_macros.svh"

module sample_fifo (
    input  logic                usr_clk,
    input  logic                usr_rst,
    input  logic                xfer_req,
    input  rp_pkg::cdc_sample_s xfer_data,
    output logic                xfer_ack,
    output logic                fifo_valid,
    output rp_pkg::adc_sample_t fifo_data,
    input  logic                fifo_pop
);

    localparam int DEPTH = `RP_FIFO_DEPTH;
    localparam int CNT_W = `RP_PTR_W + 1;

    rp_pkg::adc_sample_t mem [DEPTH];
    rp_pkg::fifo_ptr_t   wr_ptr;
    rp_pkg::fifo_ptr_t   rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                req_meta;
    logic                req_sync;
    logic                exp_seq;
    logic                full;
    logic                new_req;
    logic                wr_en;
    logic                rd_en;

    function automatic rp_pkg::fifo_ptr_t ptr_inc(input rp_pkg::fifo_ptr_t p);
        return (p == rp_pkg::fifo_ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));

    // Request seen high with no ack yet, held off while full
    assign new_req = req_sync & ~xfer_ack & ~full;
    assign wr_en   = new_req & (xfer_data.seq == exp_seq);  // Repeat of a stored word is dropped
    assign rd_en   = fifo_pop & fifo_valid;

    always_ff @(posedge usr_clk or posedge usr_rst) begin
        if (usr_rst) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            xfer_ack <= 1'b0;
            exp_seq  <= 1'b0;
        end else begin
            req_meta <= xfer_req;
            req_sync <= req_meta;
            if (new_req)
                xfer_ack <= 1'b1;
            else if (!req_sync)
                xfer_ack <= 1'b0;
            if (wr_en)
                exp_seq <= ~exp_seq;
        end
    end

    always_ff @(posedge usr_clk or posedge usr_rst) begin
        if (usr_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge usr_clk) begin
        if (wr_en)
            mem[wr_ptr] <= xfer_data.sample;
    end

    assign fifo_valid = (count != '0);
    assign fifo_data  = mem[rd_ptr];   // Show-ahead read

endmodule

// ==== logic/sample_decimator.sv ====
`include "rp_macros.svh"

module sample_decimator (
    input  logic                usr_clk,
    input  logic                usr_rst,
    input  logic                fifo_valid,
    input  rp_pkg::adc_sample_t fifo_data,
    output logic                fifo_pop,
    output logic                sum_valid,
    output rp_pkg::sum_word_t   sum_data,
    input  logic                sum_ready
);

    localparam int CNT_W = $clog2(`RP_DECIM);

    rp_pkg::decim_state_e state;
    rp_pkg::sum_word_t    acc;
    rp_pkg::sum_word_t    sample_ext;
    logic [CNT_W-1:0]     cnt;
    logic                 pop;
    logic                 last;

    assign fifo_pop   = (state == rp_pkg::ACCUM);   // No pops while a sum waits
    assign sum_valid  = (state == rp_pkg::HOLD);
    assign pop        = fifo_pop & fifo_valid;
    assign last       = (cnt == CNT_W'(`RP_DECIM - 1));
    assign sample_ext = rp_pkg::sum_word_t'(fifo_data);

    always_ff @(posedge usr_clk or posedge usr_rst) begin
        if (usr_rst) begin
            state <= rp_pkg::ACCUM;
            acc   <= '0;
            cnt   <= '0;
        end else begin
            case (state)
                rp_pkg::ACCUM: begin
                    if (pop && last) begin
                        state <= rp_pkg::HOLD;
                        acc   <= '0;
                        cnt   <= '0;
                    end else if (pop) begin
                        acc <= acc + sample_ext;
                        cnt <= cnt + 1'b1;
                    end
                end
                rp_pkg::HOLD: begin
                    if (sum_ready)
                        state <= rp_pkg::ACCUM;
                end
                default: state <= rp_pkg::ACCUM;
            endcase
        end
    end

    // Result word, stays put through HOLD
    always_ff @(posedge usr_clk) begin
        if (pop && last)
            sum_data <= acc + sample_ext;
    end

endmodule

// ==== logic/rp_acq_top.sv ====
module rp_acq_top (
    input  logic                adc_clk_in,
    input  logic                arst_n,
    input  logic                adc_valid,
    input  rp_pkg::adc_sample_t adc_data,
    output logic                adc_ready,
    output logic                sum_valid,
    output rp_pkg::sum_word_t   sum_data,
    input  logic                sum_ready,
    output logic                usr_clk,
    output logic                usr_rst,
    output logic                adc_mmcm_locked
);

    logic                adc_rst;
    logic                xfer_req;
    logic                xfer_ack;
    rp_pkg::cdc_sample_s xfer_data;
    logic                fifo_valid;
    logic                fifo_pop;
    rp_pkg::adc_sample_t fifo_data;

    rp_infrastructure i_infra (
        .adc_clk_in      (adc_clk_in),
        .arst_n          (arst_n),
        .usr_clk         (usr_clk),
        .adc_rst         (adc_rst),
        .usr_rst         (usr_rst),
        .adc_mmcm_locked (adc_mmcm_locked)
    );

    // ADC domain producer
    adc_capture i_capture (
        .adc_clk_in (adc_clk_in),
        .adc_rst    (adc_rst),
        .adc_valid  (adc_valid),
        .adc_data   (adc_data),
        .adc_ready  (adc_ready),
        .xfer_req   (xfer_req),
        .xfer_data  (xfer_data),
        .xfer_ack   (xfer_ack)
    );

    // User domain from here on
    sample_fifo i_fifo (
        .usr_clk    (usr_clk),
        .usr_rst    (usr_rst),
        .xfer_req   (xfer_req),
        .xfer_data  (xfer_data),
        .xfer_ack   (xfer_ack),
        .fifo_valid (fifo_valid),
        .fifo_data  (fifo_data),
        .fifo_pop   (fifo_pop)
    );

    sample_decimator i_decim (
        .usr_clk    (usr_clk),
        .usr_rst    (usr_rst),
        .fifo_valid (fifo_valid),
        .fifo_data  (fifo_data),
        .fifo_pop   (fifo_pop),
        .sum_valid  (sum_valid),
        .sum_data   (sum_data),
        .sum_ready  (sum_ready)
    );

endmodule

// ==== tb/rp_acq_sva.sv ====
module rp_acq_sva (
    input logic                adc_clk_in,
    input logic                usr_clk,
    input logic                adc_rst,
    input logic                usr_rst,
    input logic                adc_ready,
    input logic                xfer_req,
    input logic                xfer_ack,
    input rp_pkg::cdc_sample_s xfer_data,
    input logic                fifo_valid,
    input logic                sum_valid,
    input logic                sum_ready,
    input rp_pkg::sum_word_t   sum_data
);
    timeunit 1ns;
    timeprecision 100ps;

    // Crossing word frozen for as long as the request is up
    xfer_data_stable: assert property (@(posedge adc_clk_in) disable iff (adc_rst)
        xfer_req |=> $stable(xfer_data))
        else $error("xfer_data changed while xfer_req was high");

    ack_needs_req: assert property (@(posedge usr_clk) disable iff (usr_rst)
        $rose(xfer_ack) |-> xfer_req)
        else $error("xfer_ack rose while xfer_req was low");

    // Result word held under back-pressure
    sum_held: assert property (@(posedge usr_clk) disable iff (usr_rst)
        sum_valid && !sum_ready |=> sum_valid && $stable(sum_data))
        else $error("sum_data or sum_valid changed before the transfer");

    usr_quiet_in_reset: assert property (@(posedge usr_clk)
        usr_rst |-> !sum_valid && !fifo_valid && !xfer_ack)
        else $error("User domain output active during usr_rst");

    adc_quiet_in_reset: assert property (@(posedge adc_clk_in)
        adc_rst |-> !adc_ready && !xfer_req)
        else $error("ADC domain output active during adc_rst");

endmodule

bind rp_acq_top rp_acq_sva i_sva (
    .adc_clk_in (adc_clk_in),
    .usr_clk    (usr_clk),
    .adc_rst    (adc_rst),
    .usr_rst    (usr_rst),
    .adc_ready  (adc_ready),
    .xfer_req   (xfer_req),
    .xfer_ack   (xfer_ack),
    .xfer_data  (xfer_data),
    .fifo_valid (fifo_valid),
    .sum_valid  (sum_valid),
    .sum_ready  (sum_ready),
    .sum_data   (sum_data)
);

// ==== tb/rp_acq_tb.sv ====
`include "rp_macros.svh"

module rp_acq_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 4000;   // Whole run, 132 samples at about 16 cycles plus drain
    localparam int STALL_SAMPLES  = `RP_DECIM + `RP_FIFO_DEPTH + 1;  // Decimator, FIFO, crossing
    localparam int READY_HIGH     = 0;
    localparam int READY_LOW      = 1;
    localparam int READY_RANDOM   = 2;

    logic                adc_clk_in;
    logic                arst_n;
    logic                adc_valid;
    rp_pkg::adc_sample_t adc_data;
    logic                adc_ready;
    logic                sum_valid;
    rp_pkg::sum_word_t   sum_data;
    logic                sum_ready;
    logic                usr_clk;
    logic                usr_rst;
    logic                adc_mmcm_locked;

    rp_pkg::adc_sample_t sample_q [$];      // Accepted samples not yet seen in a sum
    logic [15:0]         data_lfsr  = 16'd83;
    logic [15:0]         ready_lfsr = 16'd83;
    int                  ready_mode = READY_HIGH;
    int                  cycle      = 0;
    int                  test_num   = 0;
    int                  tests_run  = 0;
    int                  errors     = 0;
    int                  checks     = 0;
    int                  cmp_errors = 0;
    int                  cmp_checks = 0;
    int                  sums_total = 0;
    int                  accepted_total = 0;
    int                  err_mark;
    int                  sum_mark;
    int                  acc_mark;
    rp_pkg::sum_word_t   last_sum;

    rp_acq_top i_dut (
        .adc_clk_in      (adc_clk_in),
        .arst_n          (arst_n),
        .adc_valid       (adc_valid),
        .adc_data        (adc_data),
        .adc_ready       (adc_ready),
        .sum_valid       (sum_valid),
        .sum_data        (sum_data),
        .sum_ready       (sum_ready),
        .usr_clk         (usr_clk),
        .usr_rst         (usr_rst),
        .adc_mmcm_locked (adc_mmcm_locked)
    );

    initial begin
        adc_clk_in = 1'b0;
        forever #20 adc_clk_in = ~adc_clk_in;
    end

    // 16 bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] data_bits(input int n);
        logic [15:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i = i + 1) begin
            data_lfsr = lfsr_step(data_lfsr);
            value     = {value[14:0], data_lfsr[0]};
        end
        return value;
    endfunction

    // Integer sum of one group, cut to the result width
    function automatic rp_pkg::sum_word_t reference_sum(
        input logic [`RP_DECIM-1:0][`RP_SAMPLE_W-1:0] grp
    );
        int unsigned total;
        int          i;
        total = 0;
        for (i = 0; i < `RP_DECIM; i = i + 1)
            total = total + 32'(grp[i]);
        return rp_pkg::sum_word_t'(total);
    endfunction

    // sum_ready changes just after each user clock edge
    initial begin
        sum_ready = 1'b0;
        forever begin
            @(posedge usr_clk);
            #2;
            case (ready_mode)
                READY_LOW:    sum_ready = 1'b0;
                READY_RANDOM: begin
                    ready_lfsr = lfsr_step(ready_lfsr);
                    sum_ready  = ready_lfsr[0];
                end
                default:      sum_ready = 1'b1;
            endcase
        end
    end

    always @(posedge adc_clk_in) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("Timeout: test %0d still running at cycle %0d", test_num, cycle);
            $display("Errors found");
            $finish;
        end
    end

    // Handshake state is stable at the falling edge, transfer follows at the next rise
    always @(negedge usr_clk) begin : compare
        logic [`RP_DECIM-1:0][`RP_SAMPLE_W-1:0] grp;
        rp_pkg::sum_word_t                      exp_sum;
        int                                     i;
        if (!usr_rst && sum_valid && sum_ready) begin
            if (sample_q.size() < `RP_DECIM) begin
                $display("Sum 0x%h arrived with only %0d samples accepted",
                         sum_data, sample_q.size());
                cmp_errors++;
            end else begin
                for (i = 0; i < `RP_DECIM; i = i + 1)
                    grp[i] = sample_q.pop_front();
                exp_sum = reference_sum(grp);
                cmp_checks++;
                if (sum_data !== exp_sum) begin
                    $display("Mismatch sum_data: expected 0x%h, got 0x%h", exp_sum, sum_data);
                    cmp_errors++;
                end
            end
            sums_total++;
            last_sum = sum_data;
        end
    end

    // Called 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic send_sample(input rp_pkg::adc_sample_t value);
        logic taken;
        adc_valid = 1'b1;
        adc_data  = value;
        taken     = 1'b0;
        while (!taken) begin
            taken = adc_ready;   // What the next edge will see
            @(posedge adc_clk_in);
            #2;
        end
        adc_valid = 1'b0;
        sample_q.push_back(value);
        accepted_total++;
    endtask

    task automatic send_random(input int n, input bit gaps);
        int k;
        for (k = 0; k < n; k = k + 1) begin
            if (gaps)
                repeat (int'(data_bits(2))) begin
                    @(posedge adc_clk_in);
                    #2;
                end
            send_sample(rp_pkg::adc_sample_t'(data_bits(`RP_SAMPLE_W)));
        end
    endtask

    task automatic start_test(input int num);
        test_num   = num;
        err_mark   = errors + cmp_errors;
        sum_mark   = sums_total;
        acc_mark   = accepted_total;
    endtask

    task automatic finish_test(input int exp_sums);
        int target;
        target = sum_mark + exp_sums;
        while (sums_total < target)
            @(posedge adc_clk_in);
        repeat (40) @(posedge adc_clk_in);   // Room for a stray extra sum
        #2;
        checks++;
        if (sums_total != target) begin
            $display("Test %0d gave %0d sums where %0d were due",
                     test_num, sums_total - sum_mark, exp_sums);
            errors++;
        end
        if (sample_q.size() != 0) begin
            $display("%0d accepted samples never came out in a sum", sample_q.size());
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("Test %0d %s: %0d sums, %0d errors", test_num, name,
                 sums_total - sum_mark, errors + cmp_errors - err_mark);
    endtask

    initial begin
        int waited;
        int max_total;
        arst_n    = 1'b1;
        adc_valid = 1'b0;
        adc_data  = '0;
        #1;
        arst_n = 1'b0;   // A real falling edge fires the async resets
        repeat (10) @(posedge adc_clk_in);
        #2;
        arst_n = 1'b1;

        start_test(1);
        waited = 0;
        while (!adc_mmcm_locked) begin
            checks++;
            if (sum_valid || adc_ready) begin
                $display("Output active before lock, sum_valid %0b adc_ready %0b",
                         sum_valid, adc_ready);
                errors++;
            end
            if (!usr_rst) begin
                $display("usr_rst released before lock");
                errors++;
            end
            @(posedge adc_clk_in);
            #2;
            waited++;
        end
        if (waited < `RP_LOCK_CYCLES) begin
            $display("Lock came after %0d cycles, expected %0d", waited, `RP_LOCK_CYCLES);
            errors++;
        end
        while (!adc_ready) begin
            @(posedge adc_clk_in);
            #2;
        end
        finish_test(0);
        checks++;
        if (usr_rst) begin
            $display("usr_rst still asserted long after lock");
            errors++;
        end
        report_test("lock and reset release");

        start_test(2);
        send_sample(14'h0001);
        send_sample(14'h0123);
        send_sample(14'h2000);
        send_sample(14'h3abc);
        finish_test(1);
        checks++;
        if (last_sum !== 16'h5be0) begin   // Hand total of the four samples
            $display("Mismatch sum_data: expected 0x%h, got 0x%h", 16'h5be0, last_sum);
            errors++;
        end
        report_test("single group");

        start_test(3);
        send_random(64, 1'b0);
        finish_test(16);
        report_test("streaming");

        start_test(4);
        ready_mode = READY_LOW;
        fork
            send_random(24, 1'b0);
            begin
                while (accepted_total < acc_mark + STALL_SAMPLES)
                    @(posedge adc_clk_in);
                repeat (64) begin
                    @(negedge adc_clk_in);
                    if (adc_ready) begin
                        $display("adc_ready went high while the FIFO was full");
                        errors++;
                    end
                end
                checks++;
                if (accepted_total != acc_mark + STALL_SAMPLES) begin
                    $display("Back-pressure let %0d samples in, expected %0d",
                             accepted_total - acc_mark, STALL_SAMPLES);
                    errors++;
                end
                ready_mode = READY_HIGH;
            end
        join
        finish_test(24 / `RP_DECIM);
        report_test("back-pressure");

        start_test(5);
        ready_mode = READY_RANDOM;
        send_random(32, 1'b1);
        finish_test((accepted_total - acc_mark) / `RP_DECIM);
        report_test("random handshakes");

        start_test(6);
        ready_mode = READY_HIGH;
        repeat (2 * `RP_DECIM) send_sample('1);
        finish_test(2);
        max_total = `RP_DECIM * ((1 << `RP_SAMPLE_W) - 1);
        checks++;
        if (int'(last_sum) != max_total) begin
            $display("Mismatch sum_data: expected 0x%h, got 0x%h", max_total, last_sum);
            errors++;
        end
        report_test("maximum samples");

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 tests_run, checks + cmp_checks, errors + cmp_errors);
        if (errors + cmp_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
logic/rp_pkg.sv
logic/rp_infrastructure.sv
logic/adc_capture.sv
logic/sample_fifo.sv
logic/sample_decimator.sv
logic/rp_acq_top.sv
tb/rp_acq_sva.sv
tb/rp_acq_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the acquisition testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module rp_acq_tb -f files.f -o rp_acq_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/rp_acq_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
